// ==== verilog/wi23_defs.sv ====
package wi23_defs;

   // Datapath sizes
   localparam int REGFILE_WIDTH = 32;
   localparam int OP_WIDTH      = 5;
   localparam int SHAMT_WIDTH   = 5;    // Shift count field of operand B
   localparam int SLBI_SHIFT    = 16;   // SLBI moves A up by a half word

   // ALU operation codes
   // Op[3] & Op[2] selects the inverted A input of the adder, so every
   // code that needs B minus A sits in 011xx
   localparam logic [OP_WIDTH-1:0] OP_ADD     = 5'b00000;
   localparam logic [OP_WIDTH-1:0] OP_XOR     = 5'b00010;
   localparam logic [OP_WIDTH-1:0] OP_ANDN    = 5'b00011;

   // Shift group, low two bits go straight to the shifter
   localparam logic [OP_WIDTH-1:0] OP_ROL     = 5'b00100;
   localparam logic [OP_WIDTH-1:0] OP_SLL     = 5'b00101;
   localparam logic [OP_WIDTH-1:0] OP_ROR     = 5'b00110;
   localparam logic [OP_WIDTH-1:0] OP_SRL     = 5'b00111;

   localparam logic [OP_WIDTH-1:0] OP_PASSA   = 5'b01001;  // Forward A unchanged
   localparam logic [OP_WIDTH-1:0] OP_PASSB   = 5'b01010;  // LBI
   localparam logic [OP_WIDTH-1:0] OP_SLBI    = 5'b01011;

   // Compares and subtract, all use the inverted adder
   localparam logic [OP_WIDTH-1:0] OP_SEQ     = 5'b01100;
   localparam logic [OP_WIDTH-1:0] OP_SLT     = 5'b01101;
   localparam logic [OP_WIDTH-1:0] OP_SLE     = 5'b01110;
   localparam logic [OP_WIDTH-1:0] OP_SUB     = 5'b01111;

   localparam logic [OP_WIDTH-1:0] OP_AND     = 5'b10011;
   localparam logic [OP_WIDTH-1:0] OP_OR      = 5'b10010;

   // Not in the ALU table, ALU flags an error
   localparam logic [OP_WIDTH-1:0] OP_ILLEGAL = 5'b11111;

endpackage

// ==== verilog/wi23_isa.sv ====
package wi23_isa;

   localparam int INSTR_WIDTH = 16;

   // Field positions
   localparam int OPC_HI  = 15;
   localparam int OPC_LO  = 11;
   localparam int IMM5_HI = 4;   // Short immediate in [4:0]
   localparam int IMM8_HI = 7;   // LBI and SLBI immediate in [7:0]
   localparam int FN_HI   = 1;   // Function field in [1:0]

   // Immediate forms
   localparam logic [4:0] OPC_ADDI     = 5'b01000;
   localparam logic [4:0] OPC_SUBI     = 5'b01001;
   localparam logic [4:0] OPC_XORI     = 5'b01010;
   localparam logic [4:0] OPC_ANDNI    = 5'b01011;
   localparam logic [4:0] OPC_ROLI     = 5'b10100;
   localparam logic [4:0] OPC_SLLI     = 5'b10101;
   localparam logic [4:0] OPC_RORI     = 5'b10110;
   localparam logic [4:0] OPC_SRLI     = 5'b10111;

   localparam logic [4:0] OPC_LBI      = 5'b11000;
   localparam logic [4:0] OPC_SLBI     = 5'b10010;

   // Register-register groups
   localparam logic [4:0] OPC_RR_ARITH = 5'b11011;
   localparam logic [4:0] OPC_RR_SHIFT = 5'b11010;
   localparam logic [4:0] OPC_SEQ      = 5'b11100;
   localparam logic [4:0] OPC_SLT      = 5'b11101;
   localparam logic [4:0] OPC_SLE      = 5'b11110;
   localparam logic [4:0] OPC_ULT      = 5'b11111;
   localparam logic [4:0] OPC_ULE      = 5'b00011;
   localparam logic [4:0] OPC_AND_RR   = 5'b00110;
   localparam logic [4:0] OPC_OR_RR    = 5'b00111;

   // Function field, RR_ARITH
   localparam logic [1:0] FN_ADD  = 2'b00;
   localparam logic [1:0] FN_SUB  = 2'b01;
   localparam logic [1:0] FN_XOR  = 2'b10;
   localparam logic [1:0] FN_ANDN = 2'b11;

   // Function field, RR_SHIFT
   localparam logic [1:0] FN_ROL  = 2'b00;
   localparam logic [1:0] FN_SLL  = 2'b01;
   localparam logic [1:0] FN_ROR  = 2'b10;
   localparam logic [1:0] FN_SRL  = 2'b11;

endpackage

// ==== verilog/aluCtrlIf.sv ====
`timescale 1ns/1ps

interface aluCtrlIf
   import wi23_defs::*;
();

   logic [OP_WIDTH-1:0]      op;
   logic                     unsignedOp;   // Unsigned compare or logical right shift
   logic [REGFILE_WIDTH-1:0] imm;          // Already extended
   logic                     useImm;       // B comes from imm, not rt

   modport decoder (
      output op, unsignedOp, imm, useImm
   );

   modport datapath (
      input op, unsignedOp, imm, useImm
   );

endinterface

// ==== verilog/shifter.sv ====
`timescale 1ns/1ps

module shifter
   import wi23_defs::*;
(
   input  logic [REGFILE_WIDTH-1:0] In,
   input  logic [SHAMT_WIDTH-1:0]   Cnt,
   input  logic                     UnsignedOp,
   input  logic [1:0]               Op,
   output logic [REGFILE_WIDTH-1:0] Out
);

   // One mux level per count bit, level i moves by 2**i
   logic [REGFILE_WIDTH-1:0] stage [0:SHAMT_WIDTH];
   logic                     fill;

   assign fill = ~UnsignedOp & In[REGFILE_WIDTH-1];   // Sign bit for arithmetic right
   assign stage[0] = In;

   genvar i;
   generate
      for (i = 0; i < SHAMT_WIDTH; i++) begin : stageGen
         logic [REGFILE_WIDTH-1:0] moved;

         always_comb begin
            case (Op)
               2'd0: moved = {stage[i][REGFILE_WIDTH-(2**i)-1:0],
                              stage[i][REGFILE_WIDTH-1:REGFILE_WIDTH-(2**i)]};  // Rotate left
               2'd1: moved = {stage[i][REGFILE_WIDTH-(2**i)-1:0], {(2**i){1'b0}}};
               2'd2: moved = {stage[i][(2**i)-1:0], stage[i][REGFILE_WIDTH-1:2**i]};
               default: moved = {{(2**i){fill}}, stage[i][REGFILE_WIDTH-1:2**i]};
            endcase
         end

         assign stage[i+1] = Cnt[i] ? moved : stage[i];
      end
   endgenerate

   assign Out = stage[SHAMT_WIDTH];

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/1ps

module alu
   import wi23_defs::*;
(
   // Operands and control
   input  logic [REGFILE_WIDTH-1:0] A,
   input  logic [REGFILE_WIDTH-1:0] B,
   input  logic [OP_WIDTH-1:0]      Op,
   input  logic                     UnsignedOp,

   // Result
   output logic [REGFILE_WIDTH-1:0] Out,
   output logic                     alu_err
);

   logic [REGFILE_WIDTH-1:0] aInv;
   logic [REGFILE_WIDTH-1:0] sum;
   logic [REGFILE_WIDTH-1:0] shiftOut;
   logic                     invA;
   logic                     ofl;
   logic                     isEq;
   logic                     isLe;
   logic                     isLt;
   logic                     uLt;
   logic                     uLe;

   // Codes 011xx take B minus A through ~A + 1
   assign invA = Op[3] & Op[2];
   assign aInv = A ^ {REGFILE_WIDTH{invA}};
   assign sum  = aInv + B + {{(REGFILE_WIDTH-1){1'b0}}, invA};

   shifter shift0 (
      .In         (A),
      .Cnt        (B[SHAMT_WIDTH-1:0]),
      .UnsignedOp (UnsignedOp),
      .Op         (Op[1:0]),
      .Out        (shiftOut)
   );

   // Signed overflow of the adder
   assign ofl = (sum[REGFILE_WIDTH-1] & ~aInv[REGFILE_WIDTH-1] & ~B[REGFILE_WIDTH-1]) |
                (~sum[REGFILE_WIDTH-1] & aInv[REGFILE_WIDTH-1] & B[REGFILE_WIDTH-1]);

   assign isEq = ~|sum;
   assign isLe = ~sum[REGFILE_WIDTH-1] ^ ofl;   // B - A not negative
   assign isLt = isLe & ~isEq;

   assign uLt = A < B;
   assign uLe = uLt | (A == B);

   always_comb begin
      Out     = '0;
      alu_err = 1'b0;
      case (Op)
         OP_ADD, OP_SUB: Out = sum;
         OP_XOR:         Out = A ^ B;
         OP_ANDN:        Out = A & ~B;
         OP_ROL, OP_SLL, OP_ROR, OP_SRL: Out = shiftOut;
         OP_PASSA:       Out = A;
         OP_PASSB:       Out = B;                   // LBI
         OP_SLBI:        Out = (A << SLBI_SHIFT) | B;
         OP_SEQ:         Out[0] = isEq;
         OP_SLT:         Out[0] = UnsignedOp ? uLt : isLt;
         OP_SLE:         Out[0] = UnsignedOp ? uLe : isLe;
         OP_AND:         Out = A & B;
         OP_OR:          Out = A | B;
         default:        alu_err = 1'b1;            // Out stays zero
      endcase
   end

endmodule

// ==== verilog/aluDecode.sv ====
`timescale 1ns/1ps

module aluDecode
   import wi23_defs::*;
   import wi23_isa::*;
(
   input  logic [INSTR_WIDTH-1:0] instr,
   aluCtrlIf.decoder              ctl
);

   logic [OPC_HI-OPC_LO:0]   opcode;
   logic [FN_HI:0]           fn;
   logic [REGFILE_WIDTH-1:0] immS5;
   logic [REGFILE_WIDTH-1:0] immZ5;
   logic [REGFILE_WIDTH-1:0] immS8;
   logic [REGFILE_WIDTH-1:0] immZ8;

   assign opcode = instr[OPC_HI:OPC_LO];
   assign fn     = instr[FN_HI:0];

   // Extended immediates
   assign immS5 = {{(REGFILE_WIDTH-IMM5_HI-1){instr[IMM5_HI]}}, instr[IMM5_HI:0]};
   assign immZ5 = {{(REGFILE_WIDTH-IMM5_HI-1){1'b0}}, instr[IMM5_HI:0]};
   assign immS8 = {{(REGFILE_WIDTH-IMM8_HI-1){instr[IMM8_HI]}}, instr[IMM8_HI:0]};
   assign immZ8 = {{(REGFILE_WIDTH-IMM8_HI-1){1'b0}}, instr[IMM8_HI:0]};

   always_comb begin
      ctl.op = OP_ILLEGAL;   // Anything not listed
      case (opcode)
         OPC_ADDI:   ctl.op = OP_ADD;
         OPC_SUBI:   ctl.op = OP_SUB;
         OPC_XORI:   ctl.op = OP_XOR;
         OPC_ANDNI:  ctl.op = OP_ANDN;
         OPC_ROLI:   ctl.op = OP_ROL;
         OPC_SLLI:   ctl.op = OP_SLL;
         OPC_RORI:   ctl.op = OP_ROR;
         OPC_SRLI:   ctl.op = OP_SRL;
         OPC_LBI:    ctl.op = OP_PASSB;
         OPC_SLBI:   ctl.op = OP_SLBI;
         OPC_SEQ:    ctl.op = OP_SEQ;
         OPC_SLT, OPC_ULT: ctl.op = OP_SLT;
         OPC_SLE, OPC_ULE: ctl.op = OP_SLE;
         OPC_AND_RR: ctl.op = OP_AND;
         OPC_OR_RR:  ctl.op = OP_OR;
         OPC_RR_ARITH: begin
            case (fn)
               FN_ADD:  ctl.op = OP_ADD;
               FN_SUB:  ctl.op = OP_SUB;
               FN_XOR:  ctl.op = OP_XOR;
               FN_ANDN: ctl.op = OP_ANDN;
            endcase
         end
         OPC_RR_SHIFT: begin
            case (fn)
               FN_ROL:  ctl.op = OP_ROL;
               FN_SLL:  ctl.op = OP_SLL;
               FN_ROR:  ctl.op = OP_ROR;
               FN_SRL:  ctl.op = OP_SRL;
            endcase
         end
         default: ;
      endcase
   end

   always_comb begin
      case (opcode)
         OPC_ADDI, OPC_SUBI: ctl.imm = immS5;
         OPC_LBI:            ctl.imm = immS8;
         OPC_SLBI:           ctl.imm = immZ8;
         default:            ctl.imm = immZ5;   // Logical and shift forms
      endcase
   end

   assign ctl.useImm = opcode inside {OPC_ADDI, OPC_SUBI, OPC_XORI, OPC_ANDNI, OPC_ROLI,
                                      OPC_SLLI, OPC_RORI, OPC_SRLI, OPC_LBI, OPC_SLBI};

   assign ctl.unsignedOp = (opcode inside {OPC_ULT, OPC_ULE, OPC_SRLI}) ||
                           (opcode == OPC_RR_SHIFT && fn == FN_SRL);

endmodule

// ==== verilog/execUnit.sv ====
`timescale 1ns/1ps

module execUnit
   import wi23_defs::*;
   import wi23_isa::*;
(
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     req,
   output logic                     ack,
   input  logic [INSTR_WIDTH-1:0]   instr,
   input  logic [REGFILE_WIDTH-1:0] rsVal,
   input  logic [REGFILE_WIDTH-1:0] rtVal,
   output logic [REGFILE_WIDTH-1:0] result,
   output logic                     err
);

   logic [INSTR_WIDTH-1:0]   instrQ;
   logic [REGFILE_WIDTH-1:0] rsQ;
   logic [REGFILE_WIDTH-1:0] rtQ;
   logic [REGFILE_WIDTH-1:0] opB;
   logic [REGFILE_WIDTH-1:0] aluOut;
   logic                     aluErr;
   logic                     busy;      // Request captured, result due next edge
   logic                     capture;

   aluCtrlIf ctlIf ();

   aluDecode decode0 (
      .instr (instrQ),
      .ctl   (ctlIf.decoder)
   );

   // Datapath side of the control bundle
   assign opB = ctlIf.useImm ? ctlIf.imm : rtQ;

   alu alu0 (
      .A          (rsQ),
      .B          (opB),
      .Op         (ctlIf.op),
      .UnsignedOp (ctlIf.unsignedOp),
      .Out        (aluOut),
      .alu_err    (aluErr)
   );

   assign capture = req && !ack && !busy;

   always_ff @(posedge clk) begin
      if (capture) begin
         instrQ <= instr;
         rsQ    <= rsVal;
         rtQ    <= rtVal;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         busy   <= 1'b0;
         ack    <= 1'b0;
         result <= '0;
         err    <= 1'b0;
      end else if (capture) begin
         busy <= 1'b1;
      end else if (busy) begin
         busy   <= 1'b0;
         ack    <= 1'b1;           // Held until req drops
         result <= aluOut;
         err    <= aluErr;
      end else if (ack && !req) begin
         ack <= 1'b0;
      end
   end

endmodule

// ==== tb/execUnit_sva.sv ====
`timescale 1ns/1ps

module execUnit_sva
   import wi23_defs::*;
(
   input logic                     clk,
   input logic                     rst,
   input logic                     req,
   input logic                     ack,
   input logic [REGFILE_WIDTH-1:0] result
);

   int violations = 0;   // Read by the testbench top

   // First edge with req high and ack low is the capture edge
   ackAfterCapture: assert property (@(posedge clk) disable iff (rst)
      $rose(req) && !ack |=> !ack ##1 ack)
      else begin
         $error("ack did not rise one cycle after capture");
         violations++;
      end

   holdWhileReq: assert property (@(posedge clk) disable iff (rst)
      ack && req |=> ack && $stable(result))
      else begin
         $error("ack or result changed while req was high");
         violations++;
      end

   dropAfterReq: assert property (@(posedge clk) disable iff (rst)
      ack && !req |=> !ack)
      else begin
         $error("ack stayed high after req fell");
         violations++;
      end

   lowInReset: assert property (@(posedge clk) rst |=> !ack)
      else begin
         $error("ack high during or right after reset");
         violations++;
      end

endmodule

bind execUnit execUnit_sva sva0 (
   .clk    (clk),
   .rst    (rst),
   .req    (req),
   .ack    (ack),
   .result (result)
);

// ==== tb/execChecker.sv ====
`timescale 1ns/1ps

module execChecker
   import wi23_defs::*;
   import wi23_isa::*;
(
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     req,
   input  logic                     ack,
   input  logic [INSTR_WIDTH-1:0]   instr,
   input  logic [REGFILE_WIDTH-1:0] rsVal,
   input  logic [REGFILE_WIDTH-1:0] rtVal,
   input  logic [REGFILE_WIDTH-1:0] result,
   input  logic                     err,
   output int                       checks,
   output int                       errors
);

   logic                     reqQ;
   logic                     ackQ;
   logic                     pending;   // Request seen, result not yet checked
   logic [INSTR_WIDTH-1:0]   instrS;
   logic [REGFILE_WIDTH-1:0] rsS;
   logic [REGFILE_WIDTH-1:0] rtS;
   logic [REGFILE_WIDTH-1:0] expRes;
   logic                     expErr;

   function automatic logic [31:0] shiftRef(input logic [31:0] v, input logic [4:0] cnt,
                                            input logic [1:0] kind);
      int n;
      n = int'(cnt);
      case (kind)
         FN_ROL:  return (v << n) | (v >> (32 - n));
         FN_SLL:  return v << n;
         FN_ROR:  return (v >> n) | (v << (32 - n));
         default: return v >> n;   // Both right shift forms are logical
      endcase
   endfunction

   function automatic logic [31:0] refExec(input logic [15:0] ins, input logic [31:0] rs,
                                           input logic [31:0] rt, output logic bad);
      logic [31:0] s5;
      logic [31:0] z5;
      s5 = {{27{ins[4]}}, ins[4:0]};
      z5 = {27'd0, ins[4:0]};
      bad = 1'b0;
      case (ins[15:11])
         OPC_ADDI:     return rs + s5;
         OPC_SUBI:     return s5 - rs;   // Immediate minus rs
         OPC_XORI:     return rs ^ z5;
         OPC_ANDNI:    return rs & ~z5;
         OPC_ROLI:     return shiftRef(rs, ins[4:0], FN_ROL);
         OPC_SLLI:     return shiftRef(rs, ins[4:0], FN_SLL);
         OPC_RORI:     return shiftRef(rs, ins[4:0], FN_ROR);
         OPC_SRLI:     return shiftRef(rs, ins[4:0], FN_SRL);
         OPC_LBI:      return {{24{ins[7]}}, ins[7:0]};
         OPC_SLBI:     return (rs << 16) | {24'd0, ins[7:0]};
         OPC_RR_SHIFT: return shiftRef(rs, rt[4:0], ins[1:0]);
         OPC_RR_ARITH: begin
            case (ins[1:0])
               FN_ADD:  return rs + rt;
               FN_SUB:  return rt - rs;
               FN_XOR:  return rs ^ rt;
               default: return rs & ~rt;
            endcase
         end
         OPC_SEQ:      return {31'd0, rs == rt};
         OPC_SLT:      return {31'd0, $signed(rs) < $signed(rt)};
         OPC_SLE:      return {31'd0, $signed(rs) <= $signed(rt)};
         OPC_ULT:      return {31'd0, rs < rt};
         OPC_ULE:      return {31'd0, rs <= rt};
         OPC_AND_RR:   return rs & rt;
         OPC_OR_RR:    return rs | rt;
         default: begin
            bad = 1'b1;
            return '0;
         end
      endcase
   endfunction

   always @(posedge clk) begin
      reqQ <= req;
      ackQ <= ack;
      if (rst) begin
         pending <= 1'b0;
         checks  <= 0;
         errors  <= 0;
      end else begin
         if (req && !reqQ) begin   // Inputs are stable from req rise to ack
            instrS  <= instr;
            rsS     <= rsVal;
            rtS     <= rtVal;
            pending <= 1'b1;
         end
         if (ack && !ackQ) begin
            if (!pending) begin
               $display("error at %0t: ack rose with no request outstanding", $time);
               errors <= errors + 1;
            end else begin
               expRes = refExec(instrS, rsS, rtS, expErr);
               checks  <= checks + 1;
               pending <= 1'b0;
               if (result !== expRes || err !== expErr)
                  errors <= errors + 1;
               if (result !== expRes)
                  $display("mismatch at %0t: result expected %08h got %08h (instr %04h)",
                           $time, expRes, result, instrS);
               if (err !== expErr)
                  $display("mismatch at %0t: err expected %0b got %0b (instr %04h)",
                           $time, expErr, err, instrS);
            end
         end
      end
   end

endmodule

// ==== tb/execUnit_tb.sv ====
`timescale 1ns/1ps

module execUnit_tb
   import wi23_defs::*;
   import wi23_isa::*;
();

   localparam int RESET_CYCLES = 16;
   localparam int MAX_TX       = 500;               // Rounded up from the 468 issued
   localparam int TIMEOUT      = MAX_TX * 8 + 200;  // Up to 8 cycles each plus reset

   localparam logic [4:0] ARITH_OPC [0:6] = '{OPC_ADDI, OPC_SUBI, OPC_XORI, OPC_ANDNI,
                                               OPC_RR_ARITH, OPC_AND_RR, OPC_OR_RR};
   localparam logic [4:0] SHIFT_OPC [0:3] = '{OPC_ROLI, OPC_SLLI, OPC_RORI, OPC_SRLI};
   localparam logic [4:0] CMP_OPC   [0:4] = '{OPC_SEQ, OPC_SLT, OPC_SLE, OPC_ULT, OPC_ULE};
   // No ALU mapping for these
   localparam logic [4:0] BAD_OPC   [0:7] = '{5'b00000, 5'b00001, 5'b00010, 5'b00100,
                                              5'b01100, 5'b01111, 5'b10000, 5'b11001};

   logic                     clk;
   logic                     rst;
   logic                     req;
   logic                     ack;
   logic                     err;
   logic [INSTR_WIDTH-1:0]   instr;
   logic [REGFILE_WIDTH-1:0] rsVal;
   logic [REGFILE_WIDTH-1:0] rtVal;
   logic [REGFILE_WIDTH-1:0] result;
   int                       checks;
   int                       errors;
   int                       txCount = 0;
   int                       testTx = 0;
   int                       testErr = 0;   // Error count when the test started
   int                       cycles = 0;

   execUnit dut0 (
      .clk    (clk),
      .rst    (rst),
      .req    (req),
      .ack    (ack),
      .instr  (instr),
      .rsVal  (rsVal),
      .rtVal  (rtVal),
      .result (result),
      .err    (err)
   );

   execChecker check0 (
      .clk    (clk),
      .rst    (rst),
      .req    (req),
      .ack    (ack),
      .instr  (instr),
      .rsVal  (rsVal),
      .rtVal  (rtVal),
      .result (result),
      .err    (err),
      .checks (checks),
      .errors (errors)
   );

   always #20 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT) begin
         $display("timeout: no end of test after %0d cycles", TIMEOUT);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   function automatic logic [15:0] makeInstr(input logic [4:0] opc, input logic [10:0] low);
      return {opc, low};
   endfunction

   function automatic logic [31:0] cornerValue();
      case ($urandom_range(0, 5))
         0: return 32'h0000_0000;
         1: return 32'h0000_0001;
         2: return 32'h7fff_ffff;   // Most positive
         3: return 32'h8000_0000;   // Most negative
         4: return 32'hffff_ffff;
         default: return $urandom();
      endcase
   endfunction

   // One four-phase transaction followed by a random idle gap
   task automatic runTx(input logic [15:0] ins, input logic [31:0] rs, input logic [31:0] rt);
      @(negedge clk);
      instr = ins;
      rsVal = rs;
      rtVal = rt;
      req   = 1'b1;
      @(negedge clk);
      while (!ack) @(negedge clk);
      repeat ($urandom_range(0, 1)) @(negedge clk);   // Back-pressure
      req = 1'b0;
      @(negedge clk);
      while (ack) @(negedge clk);
      repeat ($urandom_range(0, 3)) @(negedge clk);
      txCount++;
      testTx++;
   endtask

   task automatic finishTest(input string name);
      $display("test %0s %0d transactions, %0d errors", name, testTx, errors - testErr);
      testTx  = 0;
      testErr = errors;
   endtask

   initial begin
      logic [31:0] rs;
      logic [31:0] rt;
      clk   = 1'b0;
      rst   = 1'b1;
      req   = 1'b0;
      instr = '0;
      rsVal = '0;
      rtVal = '0;
      void'($urandom(32'haa75_55fb));
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      repeat (100) begin
         runTx(makeInstr(ARITH_OPC[3'($urandom_range(0, 6))], 11'($urandom())),
               $urandom(), $urandom());
      end
      finishTest("arith");

      for (int c = 0; c < 32; c++) begin   // Every count for every kind
         for (int k = 0; k < 4; k++) begin
            if ((c + k) % 2 == 0) begin   // Immediate and register forms alternate
               runTx(makeInstr(SHIFT_OPC[2'(k)], {6'($urandom()), 5'(c)}),
                     $urandom(), $urandom());
            end else begin
               runTx(makeInstr(OPC_RR_SHIFT, {9'($urandom()), 2'(k)}),
                     $urandom(), {27'($urandom()), 5'(c)});
            end
         end
      end
      finishTest("shift");

      repeat (100) begin
         rs = cornerValue();
         rt = ($urandom_range(0, 3) == 0) ? rs : cornerValue();
         runTx(makeInstr(CMP_OPC[3'($urandom_range(0, 4))], 11'($urandom())), rs, rt);
      end
      finishTest("compare");

      repeat (60) begin
         runTx(makeInstr(($urandom_range(0, 1) == 0) ? OPC_LBI : OPC_SLBI, 11'($urandom())),
               $urandom(), $urandom());
      end
      finishTest("lbi");

      repeat (40) begin   // Each illegal word followed by a legal one
         runTx(makeInstr(BAD_OPC[3'($urandom_range(0, 7))], 11'($urandom())),
               $urandom(), $urandom());
         runTx(makeInstr(OPC_ADDI, 11'($urandom())), $urandom(), $urandom());
      end
      finishTest("illegal");

      repeat (4) @(negedge clk);
      $display("summary: %0d transactions, %0d checked, %0d errors, %0d assertion failures",
               txCount, checks, errors, dut0.sva0.violations);
      if (checks != txCount)
         $display("checker saw %0d results for %0d requests", checks, txCount);
      if (errors == 0 && checks == txCount && dut0.sva0.violations == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

// ==== vlog.f ====
verilog/wi23_defs.sv
verilog/wi23_isa.sv
verilog/aluCtrlIf.sv
verilog/shifter.sv
verilog/alu.sv
verilog/aluDecode.sv
verilog/execUnit.sv
tb/execUnit_sva.sv
tb/execChecker.sv
tb/execUnit_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the execUnit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module execUnit_tb -f vlog.f -o simExec
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/simExec +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "TEST RESULT: PASS" sim.log; then
   exit 0
fi
exit 1
